/* dv/mmu_props.sv */
`timescale 1ns/1ps

module mmu_props import mmu_pkg::*; (
	input logic clk,
	input logic rst,
	input walk_state_t state,
	input logic bare,
	input logic mem_arvalid,
	input logic mem_arready,
	input logic cpu_rvalid,
	input logic cpu_rready,
	input logic cpu_arready
);

	int fail_count = 0;

	// --------------------
	// mode
	// --------------------

	// mode picked in idle stays until the walker is idle again
	mode_held: assert property (@(posedge clk) disable iff (rst)
		state != IDLE |-> bare == $past(bare))
		else begin
			$error("bare changed while a transaction is in flight");
			fail_count++;
		end

	// --------------------
	// handshakes
	// --------------------
	ar_stable: assert property (@(posedge clk) disable iff (rst)
		mem_arvalid && !mem_arready |=> mem_arvalid)
		else begin
			$error("memory arvalid withdrawn before arready");
			fail_count++;
		end

	// translated read response waits for rready, arready alongside
	r_with_ar: assert property (@(posedge clk) disable iff (rst)
		cpu_rvalid && !cpu_rready |=> cpu_rvalid && cpu_arready)
		else begin
			$error("cpu rvalid or arready dropped before cpu rready");
			fail_count++;
		end

endmodule

bind mmu_walker mmu_props i_mmu_props (
	.clk,
	.rst,
	.state,
	.bare,
	.mem_arvalid,
	.mem_arready,
	.cpu_rvalid,
	.cpu_rready,
	.cpu_arready
);

/* dv/mmu_stim.txt */
# kind satp addr data strb expect, all hex; data and strb unused for R, expect unused for W
# satp 80000001 translates with root ppn 1; L1 entries at 1004 and 1c00, L2 table at 2000
W 00000000 00001004 00000801 f 00000000
W 00000000 00001c00 00000801 f 00000000
W 00000000 0000200c 00000c0f f 00000000
W 00000000 00002014 0000000f f 00000000
W 00000000 0000201c 00000c0f f 00000000
W 00000000 00000100 a5a51234 f 00000000
W 00000000 00000104 0badf00d f 00000000
R 00000000 00000100 00000000 0 a5a51234
R 00000000 00000104 00000000 0 0badf00d
R 00000000 00001004 00000000 0 00000801
W 00000000 00003010 cafe0001 f 00000000
R 80000001 00403010 00000000 0 cafe0001
R 80000001 00405100 00000000 0 a5a51234
R 80000001 00405104 00000000 0 0badf00d
W 80000001 00403020 11223344 f 00000000
R 80000001 00403020 00000000 0 11223344
R 00000000 00003020 00000000 0 11223344
R 80000001 c0007020 00000000 0 11223344
W 80000001 c0007024 55667788 f 00000000
R 00000000 00003024 00000000 0 55667788
R 80000001 00403024 00000000 0 55667788
W 00000000 00000100 ffeeddcc 3 00000000
R 00000000 00000100 00000000 0 a5a5ddcc
W 00000000 00000100 99887766 8 00000000
R 80000001 00405100 00000000 0 99a5ddcc
W 80000001 00403020 aabbccdd 4 00000000
R 00000000 00003020 00000000 0 11bb3344
W 80000001 c0007020 00000000 9 00000000
R 80000001 00403020 00000000 0 00bb3300
W 80000001 00405104 12345678 6 00000000
R 00000000 00000104 00000000 0 0b34560d
W 00000000 00003010 deadc0de f 00000000
R 80000001 c0007010 00000000 0 deadc0de
W 80000001 00403010 0000beef 3 00000000
R 00000000 00003010 00000000 0 deadbeef
R 80000001 00403010 00000000 0 deadbeef
R 00000000 0000200c 00000000 0 00000c0f
W 00000000 00002014 00000c0f f 00000000
R 80000001 00405010 00000000 0 deadbeef
R 80000001 00405024 00000000 0 55667788

/* dv/mmu_tb.sv */
`timescale 1ns/1ps

module mmu_tb import mmu_pkg::*; ();

	localparam int OP_NS = 200;
	localparam int RST_CYCLES = 2;
	localparam int CLK_NS = 20;
	localparam resp_t OKAY = 2'b00;

	// one line of the stimulus file
	typedef struct packed {
		logic [7:0] kind;
		data_t satp;
		addr_t addr;
		data_t data;
		strb_t strb;
		data_t expect_val;
	} op_t;

	logic clk;
	logic rst;
	ar_req_t cpu_ar;
	logic cpu_arvalid;
	logic cpu_arready;
	r_rsp_t cpu_r;
	logic cpu_rvalid;
	logic cpu_rready;
	aw_req_t cpu_aw;
	logic cpu_awvalid;
	logic cpu_awready;
	w_req_t cpu_w;
	logic cpu_wvalid;
	logic cpu_wready;
	resp_t cpu_bresp;
	logic cpu_bvalid;
	logic cpu_bready;

	op_t ops[$];
	int n_ops;
	int errors;
	int passed;

	mmu_top i_mmu_top (.*);

	initial clk = 1'b0;
	always #(CLK_NS / 2) clk = ~clk;

	function automatic string mode_name(input data_t satp);
		return satp[31] ? "translated" : "bare";
	endfunction

	// --------------------
	// stimulus file
	// --------------------
	task automatic load_ops();
		int fd;
		int cnt;
		string line;
		logic [7:0] kind;
		data_t satp, addr, data, strb, expv;
		fd = $fopen("dv/mmu_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file dv/mmu_stim.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// skip comments and empty lines
				if (line.len() < 2 || line.getc(0) == "#") continue;
				cnt = $sscanf(line, "%c %h %h %h %h %h", kind, satp, addr, data, strb, expv);
				if (cnt != 6 || (kind != "W" && kind != "R")) begin
					$display("unreadable stimulus line: %s", line);
					errors++;
				end else begin
					ops.push_back({kind, satp, addr, data, strb[3:0], expv});
				end
			end
			$fclose(fd);
		end
	endtask

	// --------------------
	// cpu side driver
	// --------------------

	// handshakes are judged at the falling edge, inputs change 2 ns after the rising one
	task automatic read_op(input op_t op, output data_t got, output resp_t resp,
		output logic last);
		int delay;
		int wait_cnt;
		logic ar_hs;
		logic r_hs;
		logic done;
		delay = $urandom_range(3, 0);
		wait_cnt = 0;
		done = 1'b0;
		cpu_ar.araddr = op.addr;
		cpu_ar.arsize = 3'b010;
		cpu_ar.arlen = 8'd0;
		cpu_ar.arburst = 2'b01;
		cpu_ar.satp = op.satp;
		cpu_arvalid = 1'b1;
		cpu_rready = (delay == 0);
		while (!done) begin
			@(negedge clk);
			ar_hs = cpu_arvalid && cpu_arready;
			r_hs = cpu_rvalid && cpu_rready;
			if (r_hs) begin
				got = cpu_r.rdata;
				resp = cpu_r.rresp;
				last = cpu_r.rlast;
			end
			if (cpu_rvalid && !cpu_rready) wait_cnt++;
			@(posedge clk);
			#2;
			if (ar_hs) cpu_arvalid = 1'b0;
			if (r_hs) begin
				cpu_rready = 1'b0;
				done = 1'b1;
			end else if (wait_cnt >= delay) begin
				cpu_rready = 1'b1;
			end
		end
	endtask

	task automatic write_op(input op_t op, output resp_t resp);
		int delay;
		int wait_cnt;
		logic aw_hs;
		logic b_hs;
		logic done;
		delay = $urandom_range(3, 0);
		wait_cnt = 0;
		done = 1'b0;
		cpu_aw.awaddr = op.addr;
		cpu_aw.satp = op.satp;
		cpu_w.wdata = op.data;
		cpu_w.wstrb = op.strb;
		cpu_awvalid = 1'b1;
		cpu_wvalid = 1'b1;
		cpu_bready = (delay == 0);
		while (!done) begin
			@(negedge clk);
			aw_hs = cpu_awvalid && cpu_awready && cpu_wready;
			b_hs = cpu_bvalid && cpu_bready;
			if (b_hs) resp = cpu_bresp;
			if (cpu_bvalid && !cpu_bready) wait_cnt++;
			@(posedge clk);
			#2;
			if (aw_hs) begin
				cpu_awvalid = 1'b0;
				cpu_wvalid = 1'b0;
			end
			if (b_hs) begin
				cpu_bready = 1'b0;
				done = 1'b1;
			end else if (wait_cnt >= delay) begin
				cpu_bready = 1'b1;
			end
		end
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		data_t got;
		resp_t resp;
		logic last;
		logic ok;
		int prop_fails;
		rst = 1'b1;
		cpu_ar = '0;
		cpu_arvalid = 1'b0;
		cpu_rready = 1'b0;
		cpu_aw = '0;
		cpu_awvalid = 1'b0;
		cpu_w = '0;
		cpu_wvalid = 1'b0;
		cpu_bready = 1'b0;
		errors = 0;
		passed = 0;
		n_ops = 0;
		void'($urandom(32'h95a002e9));
		load_ops();
		n_ops = ops.size();
		if (n_ops == 0) begin
			$display("no operations found in the stimulus file");
			errors++;
		end
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
		foreach (ops[i]) begin
			ok = 1'b1;
			if (ops[i].kind == "W") begin
				write_op(ops[i], resp);
				if (resp != OKAY) begin
					$display("[ERROR] %0t op %0d: write %h bresp %0d, expected OKAY",
						$time, i, ops[i].addr, resp);
					ok = 1'b0;
				end
				$display("op %0d: %s write %h data %h strb %h %s", i, mode_name(ops[i].satp),
					ops[i].addr, ops[i].data, ops[i].strb, ok ? "ok" : "failed");
			end else begin
				read_op(ops[i], got, resp, last);
				if (got !== ops[i].expect_val) begin
					$display("[ERROR] %0t op %0d: read %h got %h expected %h",
						$time, i, ops[i].addr, got, ops[i].expect_val);
					ok = 1'b0;
				end
				if (resp != OKAY) begin
					$display("[ERROR] %0t op %0d: read %h rresp %0d, expected OKAY",
						$time, i, ops[i].addr, resp);
					ok = 1'b0;
				end
				if (last !== 1'b1) begin
					$display("[ERROR] %0t op %0d: read %h rlast %b, expected 1",
						$time, i, ops[i].addr, last);
					ok = 1'b0;
				end
				$display("op %0d: %s read %h data %h %s", i, mode_name(ops[i].satp),
					ops[i].addr, got, ok ? "ok" : "failed");
			end
			if (ok) passed++;
			else errors++;
		end
		prop_fails = i_mmu_top.i_mmu_walker.i_mmu_props.fail_count;
		if (prop_fails != 0) begin
			$display("%0d assertion failures in the walker checks", prop_fails);
			errors += prop_fails;
		end
		$display("operations %0d, passed %0d, failed %0d, errors %0d",
			n_ops, passed, n_ops - passed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// watchdog, budget per operation plus reset
	initial begin
		wait (n_ops > 0);
		#(n_ops * OP_NS + RST_CYCLES * CLK_NS);
		$display("timeout: the operations did not complete within %0d ns",
			n_ops * OP_NS + RST_CYCLES * CLK_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* hdl/axi_sram.sv */
`timescale 1ns/1ps
`include "mmu_config.svh"

module axi_sram import mmu_pkg::*; (
	input logic clk,
	input logic rst,
	input ar_req_t ar,
	input logic arvalid,
	input logic rready,
	input aw_req_t aw,
	input logic awvalid,
	input w_req_t w,
	input logic wvalid,
	input logic bready,
	output logic arready,
	output r_rsp_t r,
	output logic rvalid,
	output logic awready,
	output logic wready,
	output resp_t bresp,
	output logic bvalid
);

	localparam resp_t RESP_OKAY = 2'b00;

	data_t mem [`MEM_WORDS];
	data_t rdata_q;
	logic [`MEM_AW-1:0] rd_idx;
	logic [`MEM_AW-1:0] wr_idx;
	logic ar_fire;
	logic wr_fire;

	// word index, wraps at the memory depth
	assign rd_idx = ar.araddr[`MEM_AW+1:2];
	assign wr_idx = aw.awaddr[`MEM_AW+1:2];

	// --------------------
	// read channel
	// --------------------
	assign arready = !rvalid;
	assign ar_fire = arvalid && arready;

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// held after the handshake so the data stays visible
	always_ff @(posedge clk) begin
		if (ar_fire) rdata_q <= mem[rd_idx];
	end

	// single beat, so rlast is always set
	assign r.rdata = rdata_q;
	assign r.rresp = RESP_OKAY;
	assign r.rlast = 1'b1;

	// --------------------
	// write channels
	// --------------------

	// aw and w are taken together
	assign awready = awvalid && wvalid && !bvalid;
	assign wready = awready;
	assign wr_fire = awready;

	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid <= 1'b0;
		end else if (wr_fire) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// byte lanes merged under the strobe
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			for (int i = 0; i < 4; i++) begin
				if (w.wstrb[i]) mem[wr_idx][i*8 +: 8] <= w.wdata[i*8 +: 8];
			end
		end
	end

	assign bresp = RESP_OKAY;

endmodule

/* hdl/mmu_config.svh */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// --------------------
// on-chip memory
// --------------------

// depth in 32-bit words, 16 KiB in total
`define MEM_WORDS 4096

// word index width, log2 of MEM_WORDS
`define MEM_AW 12

// --------------------
// translation
// --------------------

// ppn of the root page table used by the stimulus
`define MMU_PT_ROOT 20'h00001

// address driven when no lookup is in progress
`define MMU_FILLER_ADDR 32'hdeadbeef

`endif

/* hdl/mmu_pkg.sv */
package mmu_pkg;

	// --------------------
	// widths with a meaning
	// --------------------
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;
	typedef logic [19:0] ppn_t;
	typedef logic [9:0] vpn_t;
	typedef logic [1:0] resp_t;

	// walker states
	typedef enum logic [3:0] {
		IDLE, BARE_RD, BARE_WR,
		PTE1_REQ, PTE1_WAIT, PTE2_REQ, PTE2_WAIT,
		ACC_RD_REQ, ACC_RD_WAIT,
		ACC_AW_W, ACC_AW, ACC_W, ACC_B_WAIT,
		RD_DONE, WR_DONE
	} walk_state_t;

	// --------------------
	// axi-lite channels
	// --------------------
	typedef struct packed {
		addr_t araddr;
		logic [2:0] arsize;
		logic [7:0] arlen;
		logic [1:0] arburst;
		data_t satp;
	} ar_req_t;

	typedef struct packed {
		addr_t awaddr;
		data_t satp;
	} aw_req_t;

	typedef struct packed {
		data_t wdata;
		strb_t wstrb;
	} w_req_t;

	typedef struct packed {
		data_t rdata;
		resp_t rresp;
		logic rlast;
	} r_rsp_t;

	// memory-side request formed by the walker
	typedef struct packed {
		addr_t araddr;
		logic [2:0] arsize;
		addr_t awaddr;
	} walk_req_t;

endpackage

/* hdl/mmu_route.sv */
`timescale 1ns/1ps

module mmu_route import mmu_pkg::*; (
	input logic bare,
	// cpu side requests
	input ar_req_t cpu_ar,
	input logic cpu_arvalid,
	input logic cpu_rready,
	input aw_req_t cpu_aw,
	input logic cpu_awvalid,
	input w_req_t cpu_w,
	input logic cpu_wvalid,
	input logic cpu_bready,
	// walker
	input walk_req_t walk_req,
	input logic walk_arvalid,
	input logic walk_rready,
	input logic walk_awvalid,
	input logic walk_wvalid,
	input logic walk_bready,
	input logic walk_arready,
	input logic walk_rvalid,
	input logic walk_awready,
	input logic walk_wready,
	input logic walk_bvalid,
	// memory side responses
	input logic mem_arready,
	input r_rsp_t mem_r,
	input logic mem_rvalid,
	input logic mem_awready,
	input logic mem_wready,
	input resp_t mem_bresp,
	input logic mem_bvalid,
	// memory side requests
	output ar_req_t mem_ar,
	output logic mem_arvalid,
	output logic mem_rready,
	output aw_req_t mem_aw,
	output logic mem_awvalid,
	output w_req_t mem_w,
	output logic mem_wvalid,
	output logic mem_bready,
	// cpu side responses
	output logic cpu_arready,
	output r_rsp_t cpu_r,
	output logic cpu_rvalid,
	output logic cpu_awready,
	output logic cpu_wready,
	output resp_t cpu_bresp,
	output logic cpu_bvalid
);

	// --------------------
	// towards memory
	// --------------------

	// burst fields and satp always follow the cpu
	always_comb begin
		mem_ar = cpu_ar;
		mem_aw = cpu_aw;
		if (!bare) begin
			mem_ar.araddr = walk_req.araddr;
			mem_ar.arsize = walk_req.arsize;
			mem_aw.awaddr = walk_req.awaddr;
		end
	end

	assign mem_w = cpu_w;
	assign mem_arvalid = bare ? cpu_arvalid : walk_arvalid;
	assign mem_rready = bare ? cpu_rready : walk_rready;
	assign mem_awvalid = bare ? cpu_awvalid : walk_awvalid;
	assign mem_wvalid = bare ? cpu_wvalid : walk_wvalid;
	assign mem_bready = bare ? cpu_bready : walk_bready;

	// --------------------
	// towards cpu
	// --------------------
	assign cpu_r = mem_r;
	assign cpu_bresp = mem_bresp;
	assign cpu_arready = bare ? mem_arready : walk_arready;
	assign cpu_rvalid = bare ? mem_rvalid : walk_rvalid;
	assign cpu_awready = bare ? mem_awready : walk_awready;
	assign cpu_wready = bare ? mem_wready : walk_wready;
	assign cpu_bvalid = bare ? mem_bvalid : walk_bvalid;

endmodule

/* hdl/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; (
	input logic clk,
	input logic rst,
	input ar_req_t cpu_ar,
	input logic cpu_arvalid,
	output logic cpu_arready,
	output r_rsp_t cpu_r,
	output logic cpu_rvalid,
	input logic cpu_rready,
	input aw_req_t cpu_aw,
	input logic cpu_awvalid,
	output logic cpu_awready,
	input w_req_t cpu_w,
	input logic cpu_wvalid,
	output logic cpu_wready,
	output resp_t cpu_bresp,
	output logic cpu_bvalid,
	input logic cpu_bready
);

	logic bare;
	walk_req_t walk_req;
	logic walk_arvalid, walk_rready, walk_awvalid, walk_wvalid, walk_bready;
	logic walk_arready, walk_rvalid, walk_awready, walk_wready, walk_bvalid;

	// memory side
	ar_req_t mem_ar;
	aw_req_t mem_aw;
	w_req_t mem_w;
	r_rsp_t mem_r;
	resp_t mem_bresp;
	logic mem_arvalid, mem_arready, mem_rvalid, mem_rready;
	logic mem_awvalid, mem_awready, mem_wvalid, mem_wready;
	logic mem_bvalid, mem_bready;

	mmu_walker i_mmu_walker (
		.clk, .rst, .cpu_ar, .cpu_arvalid, .cpu_aw, .cpu_awvalid, .cpu_wvalid,
		.cpu_rready, .cpu_bready, .mem_arready, .mem_rvalid, .mem_rdata(mem_r.rdata),
		.mem_awready, .mem_wready, .mem_bvalid, .bare, .walk_req,
		.mem_arvalid(walk_arvalid), .mem_rready(walk_rready),
		.mem_awvalid(walk_awvalid), .mem_wvalid(walk_wvalid), .mem_bready(walk_bready),
		.cpu_arready(walk_arready), .cpu_rvalid(walk_rvalid),
		.cpu_awready(walk_awready), .cpu_wready(walk_wready), .cpu_bvalid(walk_bvalid)
	);

	mmu_route i_mmu_route (
		.bare, .cpu_ar, .cpu_arvalid, .cpu_rready, .cpu_aw, .cpu_awvalid, .cpu_w,
		.cpu_wvalid, .cpu_bready, .walk_req, .walk_arvalid, .walk_rready, .walk_awvalid,
		.walk_wvalid, .walk_bready, .walk_arready, .walk_rvalid, .walk_awready,
		.walk_wready, .walk_bvalid, .mem_arready, .mem_r, .mem_rvalid, .mem_awready,
		.mem_wready, .mem_bresp, .mem_bvalid, .mem_ar, .mem_arvalid, .mem_rready,
		.mem_aw, .mem_awvalid, .mem_w, .mem_wvalid, .mem_bready, .cpu_arready, .cpu_r,
		.cpu_rvalid, .cpu_awready, .cpu_wready, .cpu_bresp, .cpu_bvalid
	);

	axi_sram i_axi_sram (
		.clk, .rst, .ar(mem_ar), .arvalid(mem_arvalid), .rready(mem_rready),
		.aw(mem_aw), .awvalid(mem_awvalid), .w(mem_w), .wvalid(mem_wvalid),
		.bready(mem_bready), .arready(mem_arready), .r(mem_r), .rvalid(mem_rvalid),
		.awready(mem_awready), .wready(mem_wready), .bresp(mem_bresp), .bvalid(mem_bvalid)
	);

endmodule

/* hdl/mmu_walker.sv */
`timescale 1ns/1ps
`include "mmu_config.svh"

module mmu_walker import mmu_pkg::*; (
	input logic clk,
	input logic rst,
	input ar_req_t cpu_ar,
	input logic cpu_arvalid,
	input aw_req_t cpu_aw,
	input logic cpu_awvalid,
	input logic cpu_wvalid,
	input logic cpu_rready,
	input logic cpu_bready,
	input logic mem_arready,
	input logic mem_rvalid,
	input data_t mem_rdata,
	input logic mem_awready,
	input logic mem_wready,
	input logic mem_bvalid,
	output logic bare,
	output walk_req_t walk_req,
	output logic mem_arvalid,
	output logic mem_rready,
	output logic mem_awvalid,
	output logic mem_wvalid,
	output logic mem_bready,
	output logic cpu_arready,
	output logic cpu_rvalid,
	output logic cpu_awready,
	output logic cpu_wready,
	output logic cpu_bvalid
);

	walk_state_t state, state_nxt;
	logic wr_q;
	data_t satp_q;
	data_t pte1_q;
	data_t pte2_q;
	logic wr_pair;
	addr_t va;
	vpn_t vpn1, vpn0;
	addr_t pte1_addr, pte2_addr, paddr;

	assign wr_pair = cpu_awvalid && cpu_wvalid;

	// --------------------
	// address formation
	// --------------------
	assign va = wr_q ? cpu_aw.awaddr : cpu_ar.araddr;
	assign vpn1 = va[31:22];
	assign vpn0 = va[21:12];
	assign pte1_addr = {ppn_t'(satp_q[19:0]), vpn1, 2'b00};
	assign pte2_addr = {ppn_t'(pte1_q[29:10]), vpn0, 2'b00};
	assign paddr = {ppn_t'(pte2_q[29:10]), va[11:0]};

	always_comb begin
		walk_req.araddr = `MMU_FILLER_ADDR;
		walk_req.awaddr = `MMU_FILLER_ADDR;
		// walk reads are always word-sized
		walk_req.arsize = 3'b010;
		case (state)
			PTE1_REQ, PTE1_WAIT: walk_req.araddr = pte1_addr;
			PTE2_REQ, PTE2_WAIT: walk_req.araddr = pte2_addr;
			ACC_RD_REQ, ACC_RD_WAIT: begin
				walk_req.araddr = paddr;
				walk_req.arsize = cpu_ar.arsize;
			end
			ACC_AW_W, ACC_AW, ACC_W, ACC_B_WAIT: walk_req.awaddr = paddr;
			default: ;
		endcase
	end

	// mode follows the pending request while idle
	always_comb begin
		case (state)
			IDLE: begin
				if (wr_pair) bare = !cpu_aw.satp[31];
				else if (cpu_arvalid) bare = !cpu_ar.satp[31];
				else bare = 1'b1;
			end
			BARE_RD, BARE_WR: bare = 1'b1;
			default: bare = 1'b0;
		endcase
	end

	// --------------------
	// strobes
	// --------------------
	assign mem_arvalid = state == PTE1_REQ || state == PTE2_REQ || state == ACC_RD_REQ;
	assign mem_rready = state == PTE1_WAIT || state == PTE2_WAIT || state == ACC_RD_WAIT;
	assign mem_awvalid = state == ACC_AW_W || state == ACC_AW;
	assign mem_wvalid = state == ACC_AW_W || state == ACC_W;
	assign mem_bready = state == ACC_B_WAIT;
	assign cpu_arready = state == RD_DONE;
	assign cpu_rvalid = state == RD_DONE;
	assign cpu_awready = state == WR_DONE;
	assign cpu_wready = state == WR_DONE;
	assign cpu_bvalid = state == WR_DONE;

	// --------------------
	// next state
	// --------------------
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				// write pair wins over a read
				if (wr_pair) begin
					if (cpu_aw.satp[31]) state_nxt = PTE1_REQ;
					else if (mem_awready && mem_wready) state_nxt = BARE_WR;
				end else if (cpu_arvalid) begin
					if (cpu_ar.satp[31]) state_nxt = PTE1_REQ;
					else if (mem_arready) state_nxt = BARE_RD;
				end
			end
			BARE_RD: if (mem_rvalid && cpu_rready) state_nxt = IDLE;
			BARE_WR: if (mem_bvalid && cpu_bready) state_nxt = IDLE;
			PTE1_REQ: if (mem_arready) state_nxt = PTE1_WAIT;
			PTE1_WAIT: if (mem_rvalid) state_nxt = PTE2_REQ;
			PTE2_REQ: if (mem_arready) state_nxt = PTE2_WAIT;
			PTE2_WAIT: if (mem_rvalid) state_nxt = wr_q ? ACC_AW_W : ACC_RD_REQ;
			ACC_RD_REQ: if (mem_arready) state_nxt = ACC_RD_WAIT;
			ACC_RD_WAIT: if (mem_rvalid) state_nxt = RD_DONE;
			ACC_AW_W: begin
				if (mem_awready && mem_wready) state_nxt = ACC_B_WAIT;
				else if (mem_awready) state_nxt = ACC_W;
				else if (mem_wready) state_nxt = ACC_AW;
			end
			ACC_AW: if (mem_awready) state_nxt = ACC_B_WAIT;
			ACC_W: if (mem_wready) state_nxt = ACC_B_WAIT;
			ACC_B_WAIT: if (mem_bvalid) state_nxt = WR_DONE;
			RD_DONE: if (cpu_rready) state_nxt = IDLE;
			WR_DONE: if (cpu_bready) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			wr_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == IDLE && state_nxt == PTE1_REQ) wr_q <= wr_pair;
		end
	end

	// latched satp and ptes
	always_ff @(posedge clk) begin
		if (state == IDLE && state_nxt == PTE1_REQ) begin
			satp_q <= wr_pair ? cpu_aw.satp : cpu_ar.satp;
		end
		if (state == PTE1_WAIT && mem_rvalid) pte1_q <= mem_rdata;
		if (state == PTE2_WAIT && mem_rvalid) pte2_q <= mem_rdata;
	end

endmodule

/* tb.f */
+incdir+hdl
hdl/mmu_pkg.sv
hdl/mmu_walker.sv
hdl/mmu_route.sv
hdl/axi_sram.sv
hdl/mmu_top.sv
dv/mmu_props.sv
dv/mmu_tb.sv
